// File: hdl/dma_axi_pkg.sv
// AXI port widths and burst constants

package dma_axi_pkg;

	localparam int data_w = 64;
	localparam int addr_w = 64;

	// Every block is one fixed-length burst
	localparam int burst_beats = 8;
	// Length field carries beats minus one
	localparam logic [7:0] burst_len = 8'(burst_beats - 1);
	localparam logic [2:0] beat_size = 3'($clog2(data_w / 8));

	// Byte offset of a block index
	localparam int block_shift = $clog2(burst_beats * data_w / 8);

	localparam int data_depth_log = 5;
	localparam int addr_depth_log = 4;

	// Beat data in the upper bits, last flag in bit 0
	typedef logic [data_w:0] beat_t;
	typedef logic [addr_w-1:0] addr_t;

endpackage

// File: hdl/dma_cmd_pkg.sv
// DMA command and completion records

package dma_cmd_pkg;

	localparam int n_channels = 4;
	localparam int count_w = 9;
	localparam int dram_blk_w = 24;
	localparam int pcie_blk_w = 28;
	// Completed-block counter per channel
	localparam int cnt_w = 64;

	// Software command word, MSB first
	typedef struct packed {
		logic dram_read;
		logic [$clog2(n_channels)-1:0] channel;
		logic [count_w-1:0] count;
		logic [dram_blk_w-1:0] dram_blk;
		logic [pcie_blk_w-1:0] pcie_blk;
	} dma_cmd_t;

	// One entry per block, consumed by its write response
	typedef struct packed {
		logic [$clog2(n_channels)-1:0] channel;
		logic dram_read;
	} cmpl_t;

endpackage

// File: hdl/dma_fifo.sv
`timescale 1ns/1ps
// Show-ahead synchronous FIFO

module dma_fifo #(
	parameter type payload_t = logic,
	parameter int depth_log = 4
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     push,
	input  payload_t din,
	output logic     full,
	input  logic     pop,
	output payload_t dout,
	output logic     empty
);

	localparam int depth = 2 ** depth_log;

	payload_t mem [depth];
	logic [depth_log-1:0] wr_ptr;
	logic [depth_log-1:0] rd_ptr;
	logic [depth_log:0] level;
	logic do_push;
	logic do_pop;

	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	// Level reaches 2**depth_log only when full
	assign full = level[depth_log];
	assign empty = level == '0;
	assign dout = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= din;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10: level <= level + 1'b1;
				2'b01: level <= level - 1'b1;
				default: level <= level;
			endcase
		end
	end

endmodule

// File: hdl/dma_cmd_decode.sv
`timescale 1ns/1ps
// DMA command queue and block sequencer

module dma_cmd_decode (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   sr_valid,
	input  logic                   sr_write,
	input  dma_cmd_pkg::dma_cmd_t  sr_wdata,
	output logic                   pcie_arvalid,
	output dma_axi_pkg::addr_t     pcie_araddr,
	output logic [7:0]             pcie_arlen,
	output logic [2:0]             pcie_arsize,
	input  logic                   pcie_arready,
	output logic                   dram_arvalid,
	output dma_axi_pkg::addr_t     dram_araddr,
	output logic [7:0]             dram_arlen,
	output logic [2:0]             dram_arsize,
	input  logic                   dram_arready,
	output logic                   wa_push,
	output dma_axi_pkg::addr_t     wa_addr,
	output logic                   wa_to_pcie,
	input  logic                   wa_full,
	output logic                   cm_push,
	output dma_cmd_pkg::cmpl_t     cm_rec,
	input  logic                   cm_full
);

	import dma_axi_pkg::*;
	import dma_cmd_pkg::*;

	typedef enum logic [1:0] {st_idle, st_issue, st_addr, st_record} state_t;

	state_t state;
	dma_cmd_t cmd;
	dma_cmd_t cq_dout;
	logic cq_push;
	logic cq_pop;
	logic cq_full;
	logic cq_empty;
	logic src_arready;
	addr_t dram_addr;
	addr_t pcie_addr;

	// Writes arriving while the queue is full are lost
	assign cq_push = sr_valid && sr_write && !cq_full;
	assign cq_pop = (state == st_idle) && !cq_empty;

	dma_fifo #(
		.payload_t(dma_cmd_t),
		.depth_log(addr_depth_log)
	) cmd_q (
		.clk(clk),
		.rst(rst),
		.push(cq_push),
		.din(sr_wdata),
		.full(cq_full),
		.pop(cq_pop),
		.dout(cq_dout),
		.empty(cq_empty)
	);

	assign dram_addr = addr_t'(cmd.dram_blk) << block_shift;
	assign pcie_addr = addr_t'(cmd.pcie_blk) << block_shift;

	// Read burst goes to the source side of the command
	assign pcie_arvalid = (state == st_issue) && !cmd.dram_read;
	assign pcie_araddr = pcie_addr;
	assign pcie_arlen = burst_len;
	assign pcie_arsize = beat_size;
	assign dram_arvalid = (state == st_issue) && cmd.dram_read;
	assign dram_araddr = dram_addr;
	assign dram_arlen = burst_len;
	assign dram_arsize = beat_size;
	assign src_arready = cmd.dram_read ? dram_arready : pcie_arready;

	// Destination address, then the completion record
	assign wa_push = (state == st_addr) && !wa_full;
	assign wa_addr = cmd.dram_read ? pcie_addr : dram_addr;
	assign wa_to_pcie = cmd.dram_read;
	assign cm_push = (state == st_record) && !cm_full;
	assign cm_rec.channel = cmd.channel;
	assign cm_rec.dram_read = cmd.dram_read;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle: begin
					if (cq_pop) begin
						state <= st_issue;
					end
				end
				st_issue: begin
					if (src_arready) begin
						state <= st_addr;
					end
				end
				st_addr: begin
					if (wa_push) begin
						state <= st_record;
					end
				end
				default: begin
					// Count holds blocks remaining minus one
					if (cm_push) begin
						state <= (cmd.count == '0) ? st_idle : st_issue;
					end
				end
			endcase
		end
	end

	// Step to the next block once its record is queued
	always_ff @(posedge clk) begin
		if (cq_pop) begin
			cmd <= cq_dout;
		end else if (cm_push) begin
			cmd.count <= cmd.count - 1'b1;
			cmd.dram_blk <= cmd.dram_blk + 1'b1;
			cmd.pcie_blk <= cmd.pcie_blk + 1'b1;
		end
	end

endmodule

// File: hdl/dma_block_mover.sv
`timescale 1ns/1ps
// DMA data buffers and write address channels

module dma_block_mover (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          wa_push,
	input  dma_axi_pkg::addr_t            wa_addr,
	input  logic                          wa_to_pcie,
	output logic                          wa_full,
	input  logic [dma_axi_pkg::data_w-1:0] pcie_rdata,
	input  logic                          pcie_rlast,
	input  logic                          pcie_rvalid,
	output logic                          pcie_rready,
	input  logic [dma_axi_pkg::data_w-1:0] dram_rdata,
	input  logic                          dram_rlast,
	input  logic                          dram_rvalid,
	output logic                          dram_rready,
	output logic                          pcie_awvalid,
	output dma_axi_pkg::addr_t            pcie_awaddr,
	output logic [7:0]                    pcie_awlen,
	output logic [2:0]                    pcie_awsize,
	input  logic                          pcie_awready,
	output logic                          dram_awvalid,
	output dma_axi_pkg::addr_t            dram_awaddr,
	output logic [7:0]                    dram_awlen,
	output logic [2:0]                    dram_awsize,
	input  logic                          dram_awready,
	output logic [dma_axi_pkg::data_w-1:0] pcie_wdata,
	output logic                          pcie_wlast,
	output logic                          pcie_wvalid,
	input  logic                          pcie_wready,
	output logic [dma_axi_pkg::data_w-1:0] dram_wdata,
	output logic                          dram_wlast,
	output logic                          dram_wvalid,
	input  logic                          dram_wready
);

	import dma_axi_pkg::*;

	// Lane 0 carries PCIe reads to DRAM, lane 1 DRAM reads to PCIe
	logic [1:0] r_valid;
	logic [1:0] r_last;
	logic [1:0] r_ready;
	logic [data_w-1:0] r_data [2];
	logic [1:0] aw_valid;
	logic [1:0] aw_ready;
	addr_t aw_addr [2];
	logic [1:0] w_valid;
	logic [1:0] w_last;
	logic [1:0] w_ready;
	logic [data_w-1:0] w_data [2];
	logic [1:0] aq_push;
	logic [1:0] aq_full;

	assign r_valid = {dram_rvalid, pcie_rvalid};
	assign r_last = {dram_rlast, pcie_rlast};
	assign r_data[0] = pcie_rdata;
	assign r_data[1] = dram_rdata;
	assign pcie_rready = r_ready[0];
	assign dram_rready = r_ready[1];

	assign aw_ready = {pcie_awready, dram_awready};
	assign dram_awvalid = aw_valid[0];
	assign dram_awaddr = aw_addr[0];
	assign dram_awlen = burst_len;
	assign dram_awsize = beat_size;
	assign pcie_awvalid = aw_valid[1];
	assign pcie_awaddr = aw_addr[1];
	assign pcie_awlen = burst_len;
	assign pcie_awsize = beat_size;

	assign w_ready = {pcie_wready, dram_wready};
	assign dram_wdata = w_data[0];
	assign dram_wlast = w_last[0];
	assign dram_wvalid = w_valid[0];
	assign pcie_wdata = w_data[1];
	assign pcie_wlast = w_last[1];
	assign pcie_wvalid = w_valid[1];

	// Route each queued address to its destination lane
	assign aq_push = {wa_push && wa_to_pcie, wa_push && !wa_to_pcie};
	assign wa_full = wa_to_pcie ? aq_full[1] : aq_full[0];

	for (genvar i = 0; i < 2; i++) begin : g_lane
		beat_t bq_dout;
		logic bq_full;
		logic bq_empty;
		logic aq_empty;
		logic first;
		logic add_cred;
		logic use_cred;
		// Blocks whose first beat is in but whose address is not yet sent
		logic [addr_depth_log:0] creds;

		dma_fifo #(
			.payload_t(beat_t),
			.depth_log(data_depth_log)
		) beat_q (
			.clk(clk),
			.rst(rst),
			.push(r_valid[i] && r_ready[i]),
			.din({r_data[i], r_last[i]}),
			.full(bq_full),
			.pop(w_valid[i] && w_ready[i]),
			.dout(bq_dout),
			.empty(bq_empty)
		);

		assign r_ready[i] = !bq_full;
		assign {w_data[i], w_last[i]} = bq_dout;
		assign w_valid[i] = !bq_empty;

		dma_fifo #(
			.payload_t(addr_t),
			.depth_log(addr_depth_log)
		) addr_q (
			.clk(clk),
			.rst(rst),
			.push(aq_push[i]),
			.din(wa_addr),
			.full(aq_full[i]),
			.pop(use_cred),
			.dout(aw_addr[i]),
			.empty(aq_empty)
		);

		assign add_cred = r_valid[i] && r_ready[i] && first;
		assign use_cred = aw_valid[i] && aw_ready[i];
		assign aw_valid[i] = !aq_empty && (creds != '0);

		always_ff @(posedge clk) begin
			if (rst) begin
				first <= 1'b1;
				creds <= '0;
			end else begin
				// Beat after a last beat opens the next block
				if (r_valid[i] && r_ready[i]) begin
					first <= r_last[i];
				end
				if (add_cred && !use_cred) begin
					creds <= creds + 1'b1;
				end else if (use_cred && !add_cred) begin
					creds <= creds - 1'b1;
				end
			end
		end
	end

endmodule

// File: hdl/dma_completion.sv
`timescale 1ns/1ps
// DMA block completion and counters

module dma_completion (
	input  logic                                       clk,
	input  logic                                       rst,
	input  logic                                       cm_push,
	input  dma_cmd_pkg::cmpl_t                         cm_rec,
	output logic                                       cm_full,
	input  logic                                       pcie_bvalid,
	input  logic                                       dram_bvalid,
	input  logic                                       sr_valid,
	input  logic                                       sr_write,
	input  logic [$clog2(dma_cmd_pkg::n_channels)-1:0] sr_addr,
	output logic                                       sr_rvalid,
	output logic [dma_cmd_pkg::cnt_w-1:0]              sr_rdata
);

	import dma_axi_pkg::*;
	import dma_cmd_pkg::*;

	cmpl_t head;
	logic cq_empty;
	logic cq_pop;
	// Index 0 is the DRAM destination, 1 the PCIe destination
	logic [1:0] b_valid;
	logic [1:0] b_take;
	logic [addr_depth_log:0] creds [2];
	logic [cnt_w-1:0] counts [n_channels];

	dma_fifo #(
		.payload_t(cmpl_t),
		.depth_log(addr_depth_log)
	) cmpl_q (
		.clk(clk),
		.rst(rst),
		.push(cm_push),
		.din(cm_rec),
		.full(cm_full),
		.pop(cq_pop),
		.dout(head),
		.empty(cq_empty)
	);

	assign b_valid = {pcie_bvalid, dram_bvalid};

	// A DRAM read completes on the PCIe side
	assign cq_pop = !cq_empty && (creds[head.dram_read] != '0);
	assign b_take = {cq_pop && head.dram_read, cq_pop && !head.dram_read};

	always_ff @(posedge clk) begin
		for (int i = 0; i < 2; i++) begin
			if (rst) begin
				creds[i] <= '0;
			end else if (b_valid[i] && !b_take[i]) begin
				creds[i] <= creds[i] + 1'b1;
			end else if (b_take[i] && !b_valid[i]) begin
				creds[i] <= creds[i] - 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int c = 0; c < n_channels; c++) begin
			if (rst) begin
				counts[c] <= '0;
			end else if (cq_pop && int'(head.channel) == c) begin
				counts[c] <= counts[c] + 1'b1;
			end
		end
	end

	// Register reads answer on the next cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			sr_rvalid <= 1'b0;
		end else begin
			sr_rvalid <= sr_valid && !sr_write;
		end
	end

	always_ff @(posedge clk) begin
		sr_rdata <= counts[sr_addr];
	end

endmodule

// File: hdl/pcim_dma_top.sv
`timescale 1ns/1ps
// PCIe to DRAM block-copy DMA

module pcim_dma_top (
	input  logic                                       clk,
	input  logic                                       rst,
	input  logic                                       sr_valid,
	input  logic                                       sr_write,
	input  logic [$clog2(dma_cmd_pkg::n_channels)-1:0] sr_addr,
	input  dma_cmd_pkg::dma_cmd_t                      sr_wdata,
	output logic                                       sr_rvalid,
	output logic [dma_cmd_pkg::cnt_w-1:0]              sr_rdata,
	output logic                                       pcie_arvalid,
	output dma_axi_pkg::addr_t                         pcie_araddr,
	output logic [7:0]                                 pcie_arlen,
	output logic [2:0]                                 pcie_arsize,
	input  logic                                       pcie_arready,
	input  logic [dma_axi_pkg::data_w-1:0]             pcie_rdata,
	input  logic                                       pcie_rlast,
	input  logic                                       pcie_rvalid,
	output logic                                       pcie_rready,
	output logic                                       pcie_awvalid,
	output dma_axi_pkg::addr_t                         pcie_awaddr,
	output logic [7:0]                                 pcie_awlen,
	output logic [2:0]                                 pcie_awsize,
	input  logic                                       pcie_awready,
	output logic [dma_axi_pkg::data_w-1:0]             pcie_wdata,
	output logic                                       pcie_wlast,
	output logic                                       pcie_wvalid,
	input  logic                                       pcie_wready,
	input  logic                                       pcie_bvalid,
	output logic                                       pcie_bready,
	output logic                                       dram_arvalid,
	output dma_axi_pkg::addr_t                         dram_araddr,
	output logic [7:0]                                 dram_arlen,
	output logic [2:0]                                 dram_arsize,
	input  logic                                       dram_arready,
	input  logic [dma_axi_pkg::data_w-1:0]             dram_rdata,
	input  logic                                       dram_rlast,
	input  logic                                       dram_rvalid,
	output logic                                       dram_rready,
	output logic                                       dram_awvalid,
	output dma_axi_pkg::addr_t                         dram_awaddr,
	output logic [7:0]                                 dram_awlen,
	output logic [2:0]                                 dram_awsize,
	input  logic                                       dram_awready,
	output logic [dma_axi_pkg::data_w-1:0]             dram_wdata,
	output logic                                       dram_wlast,
	output logic                                       dram_wvalid,
	input  logic                                       dram_wready,
	input  logic                                       dram_bvalid,
	output logic                                       dram_bready
);

	import dma_axi_pkg::*;
	import dma_cmd_pkg::*;

	// Sequencer to mover
	logic wa_push;
	addr_t wa_addr;
	logic wa_to_pcie;
	logic wa_full;

	// Sequencer to completion
	logic cm_push;
	cmpl_t cm_rec;
	logic cm_full;

	// Write responses are always accepted
	assign pcie_bready = 1'b1;
	assign dram_bready = 1'b1;

	dma_cmd_decode decode0 (.*);

	dma_block_mover mover0 (.*);

	dma_completion completion0 (.*);

endmodule

// File: bench/pcim_dma_sva.sv
`timescale 1ns/1ps
// DMA data, address and counter checks

module pcim_dma_sva (
	input logic                                       clk,
	input logic                                       rst,
	input logic                                       sr_valid,
	input logic                                       sr_write,
	input logic [$clog2(dma_cmd_pkg::n_channels)-1:0] sr_addr,
	input dma_cmd_pkg::dma_cmd_t                      sr_wdata,
	input logic                                       sr_rvalid,
	input logic [dma_cmd_pkg::cnt_w-1:0]              sr_rdata,
	input logic                                       pcie_arvalid,
	input logic                                       pcie_arready,
	input logic [7:0]                                 pcie_arlen,
	input logic [2:0]                                 pcie_arsize,
	input logic                                       pcie_rvalid,
	input logic                                       pcie_rready,
	input logic                                       pcie_awvalid,
	input logic                                       pcie_awready,
	input dma_axi_pkg::addr_t                         pcie_awaddr,
	input logic [7:0]                                 pcie_awlen,
	input logic [2:0]                                 pcie_awsize,
	input logic                                       pcie_wvalid,
	input logic                                       pcie_wready,
	input logic [dma_axi_pkg::data_w-1:0]             pcie_wdata,
	input logic                                       pcie_wlast,
	input logic                                       pcie_bvalid,
	input logic                                       pcie_bready,
	input logic                                       dram_arvalid,
	input logic                                       dram_arready,
	input logic [7:0]                                 dram_arlen,
	input logic [2:0]                                 dram_arsize,
	input logic                                       dram_rvalid,
	input logic                                       dram_rready,
	input logic                                       dram_awvalid,
	input logic                                       dram_awready,
	input dma_axi_pkg::addr_t                         dram_awaddr,
	input logic [7:0]                                 dram_awlen,
	input logic [2:0]                                 dram_awsize,
	input logic                                       dram_wvalid,
	input logic                                       dram_wready,
	input logic [dma_axi_pkg::data_w-1:0]             dram_wdata,
	input logic                                       dram_wlast,
	input logic                                       dram_bvalid,
	input logic                                       dram_bready
);

	import dma_axi_pkg::*;
	import dma_cmd_pkg::*;

	// Length field of a fixed burst, and the size code of 8-byte beats
	localparam logic [7:0] exp_len = 8'(burst_beats - 1);
	localparam logic [2:0] exp_size = 3'd3;

	// Expected destination addresses, in command order
	addr_t dram_aw_q [$];
	addr_t pcie_aw_q [$];
	// Source block addresses feeding each destination
	addr_t dram_src_q [$];
	addr_t pcie_src_q [$];
	int dram_beat;
	int pcie_beat;
	int pcie_rbeat;
	int dram_rbeat;
	int dram_started;
	int pcie_started;
	int dram_aw_cnt;
	int pcie_aw_cnt;
	int blocks_total;
	int b_seen;
	int fail_cnt;
	logic [cnt_w-1:0] exp_total [n_channels];
	logic [$clog2(n_channels)-1:0] rd_chan;
	logic [2:0] done_sr;
	logic seen_write;
	logic any_valid;
	addr_t exp_dram_awaddr;
	addr_t exp_pcie_awaddr;
	addr_t exp_dram_wdata;
	addr_t exp_pcie_wdata;
	logic dram_aw_pend;
	logic pcie_aw_pend;
	logic dram_src_pend;
	logic pcie_src_pend;

	always_comb begin
		dram_aw_pend = dram_aw_q.size() != 0;
		pcie_aw_pend = pcie_aw_q.size() != 0;
		dram_src_pend = dram_src_q.size() != 0;
		pcie_src_pend = pcie_src_q.size() != 0;
		exp_dram_awaddr = dram_aw_pend ? dram_aw_q[0] : '0;
		exp_pcie_awaddr = pcie_aw_pend ? pcie_aw_q[0] : '0;
		// Beat data is the byte address of the source beat
		exp_dram_wdata = dram_src_pend ? dram_src_q[0] + addr_t'(dram_beat * 8) : '0;
		exp_pcie_wdata = pcie_src_pend ? pcie_src_q[0] + addr_t'(pcie_beat * 8) : '0;
		any_valid = pcie_arvalid || dram_arvalid || pcie_awvalid || dram_awvalid ||
			pcie_wvalid || dram_wvalid || sr_rvalid;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			dram_aw_q.delete();
			pcie_aw_q.delete();
			dram_src_q.delete();
			pcie_src_q.delete();
			dram_beat <= 0;
			pcie_beat <= 0;
			pcie_rbeat <= 0;
			dram_rbeat <= 0;
			dram_started <= 0;
			pcie_started <= 0;
			dram_aw_cnt <= 0;
			pcie_aw_cnt <= 0;
			blocks_total <= 0;
			b_seen <= 0;
			seen_write <= 1'b0;
			done_sr <= '0;
			rd_chan <= '0;
			for (int c = 0; c < n_channels; c++) begin
				exp_total[c] <= '0;
			end
		end else begin
			rd_chan <= sr_addr;
			done_sr <= {done_sr[1:0], (b_seen == blocks_total) && (blocks_total != 0)};
			if (sr_valid && sr_write) begin
				seen_write <= 1'b1;
				blocks_total <= blocks_total + int'(sr_wdata.count) + 1;
				exp_total[sr_wdata.channel] <= exp_total[sr_wdata.channel] +
					cnt_w'(sr_wdata.count) + 1'b1;
				for (int i = 0; i <= int'(sr_wdata.count); i++) begin
					if (sr_wdata.dram_read) begin
						pcie_aw_q.push_back((addr_t'(sr_wdata.pcie_blk) + addr_t'(i)) <<
							block_shift);
						pcie_src_q.push_back((addr_t'(sr_wdata.dram_blk) + addr_t'(i)) <<
							block_shift);
					end else begin
						dram_aw_q.push_back((addr_t'(sr_wdata.dram_blk) + addr_t'(i)) <<
							block_shift);
						dram_src_q.push_back((addr_t'(sr_wdata.pcie_blk) + addr_t'(i)) <<
							block_shift);
					end
				end
			end
			// First beat of a block opens one address credit
			if (pcie_rvalid && pcie_rready) begin
				dram_started <= dram_started + ((pcie_rbeat == 0) ? 1 : 0);
				pcie_rbeat <= (pcie_rbeat + 1) % burst_beats;
			end
			if (dram_rvalid && dram_rready) begin
				pcie_started <= pcie_started + ((dram_rbeat == 0) ? 1 : 0);
				dram_rbeat <= (dram_rbeat + 1) % burst_beats;
			end
			if (dram_awvalid && dram_awready && dram_aw_pend) begin
				void'(dram_aw_q.pop_front());
				dram_aw_cnt <= dram_aw_cnt + 1;
			end
			if (pcie_awvalid && pcie_awready && pcie_aw_pend) begin
				void'(pcie_aw_q.pop_front());
				pcie_aw_cnt <= pcie_aw_cnt + 1;
			end
			if (dram_wvalid && dram_wready) begin
				dram_beat <= (dram_beat + 1) % burst_beats;
				if (dram_beat == burst_beats - 1 && dram_src_pend) begin
					void'(dram_src_q.pop_front());
				end
			end
			if (pcie_wvalid && pcie_wready) begin
				pcie_beat <= (pcie_beat + 1) % burst_beats;
				if (pcie_beat == burst_beats - 1 && pcie_src_pend) begin
					void'(pcie_src_q.pop_front());
				end
			end
			b_seen <= b_seen + (pcie_bvalid ? 1 : 0) + (dram_bvalid ? 1 : 0);
		end
	end

	initial fail_cnt = 0;

	a_idle: assert property (@(posedge clk) disable iff (rst) !seen_write |-> !any_valid)
		else begin
			$error("error at %0t: valid output high before the first command", $time);
			fail_cnt++;
		end

	// Fixed burst fields, write responses always accepted
	a_fields: assert property (@(posedge clk) disable iff (rst)
		(!pcie_arvalid || (pcie_arlen == exp_len && pcie_arsize == exp_size)) &&
		(!dram_arvalid || (dram_arlen == exp_len && dram_arsize == exp_size)) &&
		(!pcie_awvalid || (pcie_awlen == exp_len && pcie_awsize == exp_size)) &&
		(!dram_awvalid || (dram_awlen == exp_len && dram_awsize == exp_size)) &&
		pcie_bready && dram_bready)
		else begin
			$error("error at %0t: wrong burst length, burst size or response ready", $time);
			fail_cnt++;
		end

	a_dram_aw: assert property (@(posedge clk) disable iff (rst)
		dram_awvalid && dram_awready |-> dram_aw_pend && dram_awaddr == exp_dram_awaddr)
		else begin
			$error("error at %0t: DRAM write address %h, expected %h", $time,
				dram_awaddr, exp_dram_awaddr);
			fail_cnt++;
		end

	a_pcie_aw: assert property (@(posedge clk) disable iff (rst)
		pcie_awvalid && pcie_awready |-> pcie_aw_pend && pcie_awaddr == exp_pcie_awaddr)
		else begin
			$error("error at %0t: PCIe write address %h, expected %h", $time,
				pcie_awaddr, exp_pcie_awaddr);
			fail_cnt++;
		end

	a_dram_w: assert property (@(posedge clk) disable iff (rst)
		dram_wvalid && dram_wready |-> dram_src_pend && dram_wdata == exp_dram_wdata &&
		dram_wlast == (dram_beat == burst_beats - 1))
		else begin
			$error("error at %0t: DRAM write beat %h, expected %h", $time,
				dram_wdata, exp_dram_wdata);
			fail_cnt++;
		end

	a_pcie_w: assert property (@(posedge clk) disable iff (rst)
		pcie_wvalid && pcie_wready |-> pcie_src_pend && pcie_wdata == exp_pcie_wdata &&
		pcie_wlast == (pcie_beat == burst_beats - 1))
		else begin
			$error("error at %0t: PCIe write beat %h, expected %h", $time,
				pcie_wdata, exp_pcie_wdata);
			fail_cnt++;
		end

	// Write address waits for the first beat of its block
	a_dram_aw_order: assert property (@(posedge clk) disable iff (rst)
		dram_awvalid |-> dram_started > dram_aw_cnt)
		else begin
			$error("error at %0t: DRAM write address before its first beat", $time);
			fail_cnt++;
		end

	a_pcie_aw_order: assert property (@(posedge clk) disable iff (rst)
		pcie_awvalid |-> pcie_started > pcie_aw_cnt)
		else begin
			$error("error at %0t: PCIe write address before its first beat", $time);
			fail_cnt++;
		end

	a_rd_lat: assert property (@(posedge clk) disable iff (rst)
		sr_valid && !sr_write |=> sr_rvalid)
		else begin
			$error("error at %0t: register read not answered on the next cycle", $time);
			fail_cnt++;
		end

	a_rd_only: assert property (@(posedge clk) disable iff (rst)
		sr_rvalid |-> $past(sr_valid && !sr_write))
		else begin
			$error("error at %0t: register read data without a request", $time);
			fail_cnt++;
		end

	a_count: assert property (@(posedge clk) disable iff (rst)
		sr_rvalid && done_sr == 3'b111 |-> sr_rdata == exp_total[rd_chan])
		else begin
			$error("error at %0t: channel %0d count %0d, expected %0d", $time,
				rd_chan, sr_rdata, exp_total[rd_chan]);
			fail_cnt++;
		end

endmodule

bind pcim_dma_top pcim_dma_sva sva0 (.*);

// File: bench/pcim_dma_tb.sv
`timescale 1ns/1ps
// PCIe to DRAM DMA testbench

module pcim_dma_tb;

	import dma_axi_pkg::*;
	import dma_cmd_pkg::*;

	localparam int n_cmds = 10;

	logic clk = 1'b0;
	logic rst = 1'b1;
	logic sr_valid = 1'b0;
	logic sr_write = 1'b0;
	logic [$clog2(n_channels)-1:0] sr_addr = '0;
	dma_cmd_t sr_wdata = '0;
	logic sr_rvalid;
	logic [cnt_w-1:0] sr_rdata;

	// Index 0 is the PCIe port, 1 the DRAM port
	logic [1:0] arvalid;
	logic [1:0] rready;
	logic [1:0] awvalid;
	logic [1:0] wvalid;
	logic [1:0] wlast;
	logic [1:0] bready;
	addr_t araddr [2];
	addr_t awaddr [2];
	logic [7:0] arlen [2];
	logic [7:0] awlen [2];
	logic [2:0] arsize [2];
	logic [2:0] awsize [2];
	logic [data_w-1:0] wdata [2];
	logic [1:0] arready = '0;
	logic [1:0] rvalid = '0;
	logic [1:0] rlast = '0;
	logic [1:0] awready = '0;
	logic [1:0] wready = '0;
	logic [1:0] bvalid = '0;
	logic [data_w-1:0] rdata [2] = '{default: '0};

	addr_t rd_q [2][$];
	int rbeat [2];
	int aw_cnt [2];
	int wl_cnt [2];
	int b_cnt [2];
	int b_seen;
	int total_blocks;
	logic [31:0] rng;
	dma_cmd_t cmds [n_cmds];

	always #20 clk = ~clk;

	pcim_dma_top dut0 (
		.clk(clk), .rst(rst),
		.sr_valid(sr_valid), .sr_write(sr_write), .sr_addr(sr_addr), .sr_wdata(sr_wdata),
		.sr_rvalid(sr_rvalid), .sr_rdata(sr_rdata),
		.pcie_arvalid(arvalid[0]), .pcie_araddr(araddr[0]), .pcie_arlen(arlen[0]),
		.pcie_arsize(arsize[0]), .pcie_arready(arready[0]),
		.pcie_rdata(rdata[0]), .pcie_rlast(rlast[0]), .pcie_rvalid(rvalid[0]),
		.pcie_rready(rready[0]),
		.pcie_awvalid(awvalid[0]), .pcie_awaddr(awaddr[0]), .pcie_awlen(awlen[0]),
		.pcie_awsize(awsize[0]), .pcie_awready(awready[0]),
		.pcie_wdata(wdata[0]), .pcie_wlast(wlast[0]), .pcie_wvalid(wvalid[0]),
		.pcie_wready(wready[0]), .pcie_bvalid(bvalid[0]), .pcie_bready(bready[0]),
		.dram_arvalid(arvalid[1]), .dram_araddr(araddr[1]), .dram_arlen(arlen[1]),
		.dram_arsize(arsize[1]), .dram_arready(arready[1]),
		.dram_rdata(rdata[1]), .dram_rlast(rlast[1]), .dram_rvalid(rvalid[1]),
		.dram_rready(rready[1]),
		.dram_awvalid(awvalid[1]), .dram_awaddr(awaddr[1]), .dram_awlen(awlen[1]),
		.dram_awsize(awsize[1]), .dram_awready(awready[1]),
		.dram_wdata(wdata[1]), .dram_wlast(wlast[1]), .dram_wvalid(wvalid[1]),
		.dram_wready(wready[1]), .dram_bvalid(bvalid[1]), .dram_bready(bready[1])
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// True with roughly pct percent probability
	function automatic logic chance(input int pct);
		rng = xorshift(rng);
		return (rng % 100) < 32'(pct);
	endfunction

	// Memory models for both ports, reads answered in order
	always @(posedge clk) begin
		if (rst) begin
			for (int p = 0; p < 2; p++) begin
				rd_q[p].delete();
				rbeat[p] = 0;
				aw_cnt[p] = 0;
				wl_cnt[p] = 0;
				b_cnt[p] = 0;
			end
			b_seen = 0;
		end else begin
			for (int p = 0; p < 2; p++) begin
				if (arvalid[p] && arready[p]) begin
					rd_q[p].push_back(araddr[p]);
				end
				if (rvalid[p] && rready[p]) begin
					if (rbeat[p] == burst_beats - 1) begin
						rbeat[p] = 0;
						void'(rd_q[p].pop_front());
					end else begin
						rbeat[p]++;
					end
				end
				if (awvalid[p] && awready[p]) begin
					aw_cnt[p]++;
				end
				if (wvalid[p] && wready[p] && wlast[p]) begin
					wl_cnt[p]++;
				end
				if (bvalid[p]) begin
					b_cnt[p]++;
					b_seen++;
				end
			end
		end
		#1;
		for (int p = 0; p < 2; p++) begin
			arready[p] = chance(60);
			rvalid[p] = (rd_q[p].size() != 0) && chance(70);
			rdata[p] = (rd_q[p].size() != 0) ? rd_q[p][0] + addr_t'(rbeat[p] * 8) : '0;
			rlast[p] = rbeat[p] == burst_beats - 1;
			awready[p] = chance(50);
			wready[p] = chance(65);
			// A response needs both the address and the last beat of its block
			bvalid[p] = (b_cnt[p] < aw_cnt[p]) && (b_cnt[p] < wl_cnt[p]) && chance(50);
		end
	end

	always @(posedge clk) begin
		if (dut0.sva0.fail_cnt != 0) begin
			$display("an assertion check failed");
			$display("TEST RESULT: FAIL");
			$fatal(1, "stopping after assertion failure");
		end
	end

	task automatic fail_timeout(input string what);
		$display("timeout while waiting for %s", what);
		$display("TEST RESULT: FAIL");
		$fatal(1, "timeout");
	endtask

	task automatic read_count(input int ch);
		int cyc;
		@(posedge clk);
		#1;
		sr_valid = 1'b1;
		sr_write = 1'b0;
		sr_addr = ch[1:0];
		@(posedge clk);
		#1;
		sr_valid = 1'b0;
		cyc = 0;
		while (!sr_rvalid && cyc < 10) begin
			@(posedge clk);
			#1;
			cyc++;
		end
		if (!sr_rvalid) begin
			fail_timeout("a register read response");
		end
	endtask

	initial begin
		int cyc;
		rng = 32'd29;
		total_blocks = 0;
		// Commands picked up front, alternating directions, non-overlapping blocks
		for (int k = 0; k < n_cmds; k++) begin
			cmds[k] = '0;
			cmds[k].dram_read = 1'(k % 2);
			rng = xorshift(rng);
			cmds[k].channel = 2'(rng % n_channels);
			rng = xorshift(rng);
			cmds[k].count = 9'(rng % 4);
			cmds[k].dram_blk = 24'(k * 8 + 16);
			cmds[k].pcie_blk = 28'(28'h0100000 + k * 8);
			total_blocks += int'(cmds[k].count) + 1;
		end
		repeat (10) @(posedge clk);
		#1;
		rst = 1'b0;
		repeat (5) @(posedge clk);
		for (int k = 0; k < n_cmds; k++) begin
			@(posedge clk);
			#1;
			sr_valid = 1'b1;
			sr_write = 1'b1;
			sr_wdata = cmds[k];
			@(posedge clk);
			#1;
			sr_valid = 1'b0;
			sr_write = 1'b0;
		end
		cyc = 0;
		while (b_seen < total_blocks && cyc < 20000) begin
			@(posedge clk);
			#1;
			cyc++;
		end
		if (b_seen < total_blocks) begin
			fail_timeout("all write responses");
		end
		// Completion records drain one per cycle after the last response
		repeat (2 ** addr_depth_log + 4) @(posedge clk);
		for (int ch = 0; ch < n_channels; ch++) begin
			read_count(ch);
		end
		repeat (2) @(posedge clk);
		if (dut0.sva0.fail_cnt != 0) begin
			$display("TEST RESULT: FAIL");
			$fatal(1, "assertion failures");
		end else begin
			$display("TEST RESULT: PASS");
			$finish;
		end
	end

endmodule

// File: pcim_dma.f
hdl/dma_axi_pkg.sv
hdl/dma_cmd_pkg.sv
hdl/dma_fifo.sv
hdl/dma_cmd_decode.sv
hdl/dma_block_mover.sv
hdl/dma_completion.sv
hdl/pcim_dma_top.sv
bench/pcim_dma_sva.sv
bench/pcim_dma_tb.sv

// File: run.sh
#!/bin/bash
# Compile with Verilator, run, and judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module pcim_dma_tb \
	-f pcim_dma.f -o pcim_dma_sim > build.log 2>&1 &&
	./obj_dir/pcim_dma_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log 2>/dev/null
[ -f sim.log ] && ! grep -q "TEST RESULT: FAIL" sim.log &&
	grep -q "TEST RESULT: PASS" sim.log || { echo "simulation failed"; exit 1; }
echo "simulation passed"
